//--- project.f
common/cdd_packet_pkg.sv
common/cdd_link_pkg.sv
common/cdd_xfer_if.sv
common/cdd_byte_if.sv
cdd/cdd_host_mailbox.sv
cdd/cdd_byte_sequencer.sv
cdd/cdd_bit_shifter.sv
verilog/cdd_bridge.sv
dv/cdd_bridge_sva.sv
dv/cdd_bridge_tb.sv

//--- Bender.yml
package:
  name: cdd_bridge

sources:
  - common/cdd_packet_pkg.sv
  - common/cdd_link_pkg.sv
  - common/cdd_xfer_if.sv
  - common/cdd_byte_if.sv
  - cdd/cdd_host_mailbox.sv
  - cdd/cdd_byte_sequencer.sv
  - cdd/cdd_bit_shifter.sv
  - verilog/cdd_bridge.sv
  - target: test
    files:
      - dv/cdd_bridge_sva.sv
      - dv/cdd_bridge_tb.sv

//--- dv/cdd_bridge_tb.sv
module cdd_bridge_tb import cdd_packet_pkg::*; ();

	localparam int HOLD_OFF        = 16;
	localparam int CLK_PERIOD      = 4;
	localparam int NUM_TESTS       = 5;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 13 * 8 * 6 + 200;

	logic        clk_sys;
	logic        reset;
	cdd_packet_t host_stat_packet;
	logic        host_stat_toggle;
	cdd_packet_t host_cmd_packet;
	logic        host_cmd_toggle;
	logic        com_clk;
	logic        com_hdata;
	logic        com_cdata;
	logic        com_req_n;
	logic        com_sync_n;

	// expected status bytes, core command bytes, expected command toggle
	cdd_packet_t stat_exp;
	cdd_packet_t cmd_model;
	logic        toggle_exp;

	cdd_bridge #(.HOLD_OFF_CYCLES(HOLD_OFF)) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the bridge stopped answering before the tests ended");
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	task automatic report_assertion_failure();
		$display("a link protocol assertion failed");
		$display("CHECKS FAILED");
		$fatal(1, "assertion failure");
	endtask

	// a failed protocol assertion ends the run at once
	initial begin
		wait (uut.sva.fail_count != 0);
		report_assertion_failure();
	end

	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_value(input string name, input logic [95:0] expected,
			input logic [95:0] actual);
		if (actual !== expected) begin
			$display("** Error [%s] expected %h actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	function automatic cdd_packet_t random_packet();
		cdd_packet_t p;
		for (int i = 0; i < CDD_PACKET_BYTES; i++)
			p[i] = cdd_byte_t'($urandom);
		return p;
	endfunction

	task automatic post_status(input cdd_packet_t p);
		host_stat_packet = p;
		host_stat_toggle = ~host_stat_toggle;
	endtask

	// core side of one byte
	// com_clk idles high
	task automatic shift_byte(input string name, input cdd_byte_t hbyte, input logic sync_exp,
			output cdd_byte_t cbyte);
		for (int i = 0; i < 8; i++) begin
			com_clk = 1'b0;
			repeat (3) step_cycle();
			check_value({name, " sync"}, sync_exp, com_sync_n);
			com_hdata = hbyte[i];
			com_clk   = 1'b1;
			repeat (3) step_cycle();
			cbyte[i] = com_cdata;
		end
	endtask

	task automatic run_bytes(input string name, input int first, input int last);
		cdd_byte_t got;
		for (int b = first; b <= last; b++) begin
			while (com_req_n)
				step_cycle();
			check_value({name, " early publish"}, toggle_exp, host_cmd_toggle);
			shift_byte(name, cmd_model[b], (b != 0), got);
			check_value($sformatf("%s status byte %0d", name, b), stat_exp[b], got);
		end
	endtask

	task automatic await_publish(input string name);
		while (host_cmd_toggle == toggle_exp)
			step_cycle();
		toggle_exp = ~toggle_exp;
		check_value({name, " cmd packet"}, cmd_model, host_cmd_packet);
		// one flip per exchange and no further request
		repeat (20) begin
			step_cycle();
			check_value({name, " req after end"}, 1'b1, com_req_n);
			check_value({name, " second flip"}, toggle_exp, host_cmd_toggle);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		check_value("reset req_n", 1'b1, com_req_n);
		check_value("reset sync_n", 1'b1, com_sync_n);
		check_value("reset cdata", 1'b0, com_cdata);
		check_value("reset cmd toggle", 1'b0, host_cmd_toggle);
	endtask

	task automatic test_idle_quiet();
		repeat (50) begin
			step_cycle();
			check_value("idle req_n", 1'b1, com_req_n);
		end
	endtask

	task automatic test_single_exchange();
		stat_exp  = random_packet();
		cmd_model = random_packet();
		post_status(stat_exp);
		for (int i = 0; i < HOLD_OFF; i++) begin
			step_cycle();
			check_value("hold-off sync_n", 1'b1, com_sync_n);
		end
		step_cycle();
		check_value("sync_n after hold-off", 1'b0, com_sync_n);
		run_bytes("single", 0, CDD_PACKET_BYTES - 1);
		await_publish("single");
	endtask

	task automatic test_back_to_back();
		for (int n = 0; n < 2; n++) begin
			stat_exp  = random_packet();
			cmd_model = random_packet();
			post_status(stat_exp);
			run_bytes($sformatf("back to back %0d", n), 0, CDD_PACKET_BYTES - 1);
			await_publish($sformatf("back to back %0d", n));
		end
	endtask

	task automatic test_restart();
		stat_exp  = random_packet();
		cmd_model = random_packet();
		post_status(stat_exp);
		run_bytes("restart aborted", 0, 3);
		// byte 4 is loaded and waits for com_clk
		stat_exp  = random_packet();
		cmd_model = random_packet();
		post_status(stat_exp);
		while (com_sync_n)
			step_cycle();
		repeat (2) step_cycle();
		run_bytes("restart", 0, CDD_PACKET_BYTES - 1);
		await_publish("restart");
	endtask

	initial begin
		void'($urandom(32'hf299_1bbc));
		reset            = 1'b1;
		host_stat_packet = '0;
		host_stat_toggle = 1'b0;
		com_clk          = 1'b1;
		com_hdata        = 1'b0;
		toggle_exp       = 1'b0;
		repeat (2) step_cycle();
		reset = 1'b0;
		test_reset_state();
		test_idle_quiet();
		test_single_exchange();
		test_back_to_back();
		test_restart();
		if (uut.sva.fail_count != 0) begin
			report_assertion_failure();
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- dv/cdd_bridge_sva.sv
// link protocol checks, bound into the bridge top level
module cdd_bridge_sva (
	input logic clk_sys,
	input logic reset,
	input logic com_clk,
	input logic com_cdata,
	input logic com_req_n,
	input logic com_sync_n,
	input logic host_cmd_toggle,
	input logic cmd_ready
);

	// number of assertion failures so far
	int fail_count = 0;

	// request and sync lines are always driven once out of reset
	link_lines_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown({com_req_n, com_sync_n}))
		else begin
			$error("com_req_n or com_sync_n is unknown");
			fail_count = fail_count + 1;
		end

	// the host only sees a new command packet right after cmd_ready
	cmd_toggle_after_ready: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(host_cmd_toggle) |-> $past(cmd_ready))
		else begin
			$error("host_cmd_toggle changed without cmd_ready");
			fail_count = fail_count + 1;
		end

	// com_clk is seen one cycle late, so a change follows a seen 1 to 0 step
	cdata_after_fall: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(com_cdata) |-> ($past(!com_clk) && $past(com_clk, 2)))
		else begin
			$error("com_cdata changed without a falling com_clk edge");
			fail_count = fail_count + 1;
		end

endmodule

bind cdd_bridge cdd_bridge_sva sva (
	.clk_sys         (clk_sys),
	.reset           (reset),
	.com_clk         (com_clk),
	.com_cdata       (com_cdata),
	.com_req_n       (com_req_n),
	.com_sync_n      (com_sync_n),
	.host_cmd_toggle (host_cmd_toggle),
	.cmd_ready       (xfer_bus.cmd_ready)
);

//--- verilog/cdd_bridge.sv
module cdd_bridge import cdd_packet_pkg::*; #(
	parameter int HOLD_OFF_CYCLES = 16
) (
	input  logic        clk_sys,
	input  logic        reset,

	// host mailbox
	input  cdd_packet_t host_stat_packet,
	input  logic        host_stat_toggle,
	output cdd_packet_t host_cmd_packet,
	output logic        host_cmd_toggle,

	// core cd drive port
	input  logic        com_clk,
	input  logic        com_hdata,
	output logic        com_cdata,
	output logic        com_req_n,
	output logic        com_sync_n
);

	cdd_xfer_if xfer_bus ();
	cdd_byte_if byte_bus ();

	cdd_host_mailbox #(
		.HOLD_OFF_CYCLES (HOLD_OFF_CYCLES)
	) u_mailbox (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.host_stat_packet (host_stat_packet),
		.host_stat_toggle (host_stat_toggle),
		.host_cmd_packet  (host_cmd_packet),
		.host_cmd_toggle  (host_cmd_toggle),
		.xfer             (xfer_bus.mailbox)
	);

	cdd_byte_sequencer u_sequencer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.com_sync_n (com_sync_n),
		.xfer       (xfer_bus.sequencer),
		.bytes      (byte_bus.sequencer)
	);

	cdd_bit_shifter u_shifter (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.com_clk   (com_clk),
		.com_hdata (com_hdata),
		.com_cdata (com_cdata),
		.com_req_n (com_req_n),
		.bytes     (byte_bus.shifter)
	);

endmodule

//--- cdd/cdd_bit_shifter.sv
module cdd_bit_shifter import cdd_packet_pkg::*, cdd_link_pkg::*; (
	input  logic clk_sys,
	input  logic reset,

	input  logic com_clk,
	input  logic com_hdata,
	output logic com_cdata,
	output logic com_req_n,

	cdd_byte_if.shifter bytes
);

	logic         com_clk_q;
	logic         clk_rise;
	logic         clk_fall;
	logic         busy;
	logic         last_bit;
	cdd_bit_idx_t bit_cnt;
	cdd_byte_t    tx_shift;
	cdd_byte_t    rx_shift;

	// com_clk is already in the clk_sys domain
	assign clk_rise = com_clk && !com_clk_q;
	assign clk_fall = !com_clk && com_clk_q;
	assign last_bit = (bit_cnt == cdd_bit_idx_t'(CDD_BITS_PER_BYTE - 1));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			com_clk_q  <= 1'b0;
			busy       <= 1'b0;
			bit_cnt    <= '0;
			com_cdata  <= 1'b0;
			com_req_n  <= 1'b1;
			bytes.done <= 1'b0;
		end else begin
			com_clk_q  <= com_clk;
			bytes.done <= 1'b0;
			if (bytes.load) begin
				// a load over a byte in flight drops that byte
				busy      <= 1'b1;
				bit_cnt   <= '0;
				com_req_n <= 1'b0;
			end else if (busy && clk_fall) begin
				com_cdata <= tx_shift[0];
			end else if (busy && clk_rise) begin
				// the core has taken the request once it clocks
				com_req_n <= 1'b1;
				bit_cnt   <= bit_cnt + 3'd1;
				if (last_bit) begin
					busy       <= 1'b0;
					bytes.done <= 1'b1;
				end
			end
		end
	end

	// shift registers, lsb first in both directions
	always_ff @(posedge clk_sys) begin
		if (bytes.load)
			tx_shift <= bytes.tx_byte;
		else if (busy && clk_fall)
			tx_shift <= {1'b0, tx_shift[7:1]};
		if (!bytes.load && busy && clk_rise)
			rx_shift <= {com_hdata, rx_shift[7:1]};
	end

	assign bytes.rx_byte = rx_shift;

endmodule

//--- cdd/cdd_byte_sequencer.sv
module cdd_byte_sequencer import cdd_packet_pkg::*, cdd_link_pkg::*; (
	input  logic clk_sys,
	input  logic reset,

	output logic com_sync_n,

	cdd_xfer_if.sequencer xfer,
	cdd_byte_if.sequencer bytes
);

	cdd_seq_state_e state;
	cdd_byte_idx_t  byte_idx;
	cdd_byte_idx_t  next_idx;
	cdd_byte_idx_t  tx_idx;
	cdd_packet_t    cmd_q;
	logic           byte_done;
	logic           last_byte;

	assign byte_done = bytes.done && (state != SEQ_IDLE);
	assign last_byte = (byte_idx == CDD_LAST_BYTE);
	assign next_idx  = byte_idx + 4'd1;

	////////////////////////////////////////////////////////////////////////////
	// byte issue
	////////////////////////////////////////////////////////////////////////////

	// start always restarts at byte 0, even over a byte in flight
	assign tx_idx = (xfer.start || last_byte) ? '0 : next_idx;

	assign bytes.load    = xfer.start || (byte_done && !last_byte);
	assign bytes.tx_byte = xfer.stat_packet[tx_idx];

	// low for the whole of byte 0, starting with the load itself
	assign com_sync_n = !(xfer.start || (state == SEQ_SYNC_BYTE));

	////////////////////////////////////////////////////////////////////////////
	// state and byte index
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state          <= SEQ_IDLE;
			byte_idx       <= '0;
			xfer.cmd_ready <= 1'b0;
		end else begin
			xfer.cmd_ready <= 1'b0;
			if (xfer.start) begin
				state    <= SEQ_SYNC_BYTE;
				byte_idx <= '0;
			end else if (byte_done) begin
				if (last_byte) begin
					state          <= SEQ_IDLE;
					byte_idx       <= '0;
					xfer.cmd_ready <= 1'b1;
				end else begin
					state    <= SEQ_DATA_BYTE;
					byte_idx <= next_idx;
				end
			end
		end
	end

	// received command bytes land at the index they were exchanged on
	always_ff @(posedge clk_sys) begin
		if (byte_done && !xfer.start)
			cmd_q[byte_idx] <= bytes.rx_byte;
	end

	assign xfer.cmd_packet = cmd_q;

endmodule

//--- cdd/cdd_host_mailbox.sv
module cdd_host_mailbox import cdd_packet_pkg::*; #(
	parameter int HOLD_OFF_CYCLES = 16
) (
	input  logic        clk_sys,
	input  logic        reset,

	input  cdd_packet_t host_stat_packet,
	input  logic        host_stat_toggle,
	output cdd_packet_t host_cmd_packet,
	output logic        host_cmd_toggle,

	cdd_xfer_if.mailbox xfer
);

	localparam int HOLD_W = $clog2(HOLD_OFF_CYCLES);

	logic              stat_toggle_seen;
	logic              toggle_change;
	logic              hold_pending;
	logic [HOLD_W-1:0] hold_cnt;
	logic              hold_expired;
	logic              publish;
	cdd_packet_t       stat_latch;
	cdd_packet_t       stat_q;

	assign toggle_change = (host_stat_toggle != stat_toggle_seen);
	assign hold_expired  = hold_pending && (hold_cnt == '0);

	// an exchange that was overtaken by a new toggle is not published
	assign publish = xfer.cmd_ready && !hold_pending && !toggle_change;

	////////////////////////////////////////////////////////////////////////////
	// toggle detection and hold-off
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stat_toggle_seen <= 1'b0;
			hold_pending     <= 1'b0;
			hold_cnt         <= '0;
			xfer.start       <= 1'b0;
		end else begin
			xfer.start <= 1'b0;
			if (toggle_change) begin
				// new status, restart the hold-off even mid exchange
				stat_toggle_seen <= host_stat_toggle;
				hold_pending     <= 1'b1;
				hold_cnt         <= HOLD_W'(HOLD_OFF_CYCLES - 1);
			end else if (hold_expired) begin
				hold_pending <= 1'b0;
				xfer.start   <= 1'b1;
			end else if (hold_pending) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	// status staging, handed to the sequencer together with start
	always_ff @(posedge clk_sys) begin
		if (toggle_change)
			stat_latch <= host_stat_packet;
		if (hold_expired && !toggle_change)
			stat_q <= stat_latch;
	end

	assign xfer.stat_packet = stat_q;

	////////////////////////////////////////////////////////////////////////////
	// command publishing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset)
			host_cmd_toggle <= 1'b0;
		else if (publish)
			host_cmd_toggle <= ~host_cmd_toggle;
	end

	always_ff @(posedge clk_sys) begin
		if (publish)
			host_cmd_packet <= xfer.cmd_packet;
	end

endmodule

//--- common/cdd_byte_if.sv
// one byte at a time between the sequencer and the bit shifter
interface cdd_byte_if import cdd_packet_pkg::*; ();

	// sequencer to shifter
	logic      load;
	cdd_byte_t tx_byte;

	// shifter to sequencer, rx_byte valid while done is high
	cdd_byte_t rx_byte;
	logic      done;

	modport sequencer (
		output load,
		output tx_byte,
		input  rx_byte,
		input  done
	);

	modport shifter (
		input  load,
		input  tx_byte,
		output rx_byte,
		output done
	);

endinterface

//--- common/cdd_xfer_if.sv
// packet handoff between the host mailbox and the byte sequencer
interface cdd_xfer_if import cdd_packet_pkg::*; ();

	// mailbox to sequencer
	logic        start;
	cdd_packet_t stat_packet;

	// sequencer to mailbox, packet valid while cmd_ready is high
	cdd_packet_t cmd_packet;
	logic        cmd_ready;

	modport mailbox (
		output start,
		output stat_packet,
		input  cmd_packet,
		input  cmd_ready
	);

	modport sequencer (
		input  start,
		input  stat_packet,
		output cmd_packet,
		output cmd_ready
	);

endinterface

//--- common/cdd_link_pkg.sv
package cdd_link_pkg;

	////////////////////////////////////////////////////////////////////////////
	// serial link to the core's cd drive port
	////////////////////////////////////////////////////////////////////////////

	// bits per byte on com_cdata and com_hdata
	localparam int CDD_BITS_PER_BYTE = 8;

	// counts the bits of the byte in flight
	typedef logic [2:0] cdd_bit_idx_t;

	// sequencer state
	// sync byte is byte 0, the one with com_sync_n held low
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_SYNC_BYTE,
		SEQ_DATA_BYTE
	} cdd_seq_state_e;

endpackage

//--- common/cdd_packet_pkg.sv
package cdd_packet_pkg;

	////////////////////////////////////////////////////////////////////////////
	// packet layout shared by the host mailbox and the byte sequencer
	////////////////////////////////////////////////////////////////////////////

	// one byte as it travels on the link
	typedef logic [7:0] cdd_byte_t;

	// status and command packets are the same size
	localparam int CDD_PACKET_BYTES = 12;

	// position of a byte inside a packet
	typedef logic [3:0] cdd_byte_idx_t;

	// index of the final byte of an exchange
	localparam cdd_byte_idx_t CDD_LAST_BYTE = cdd_byte_idx_t'(CDD_PACKET_BYTES - 1);

	// byte 0 sits in bits 7:0
	typedef cdd_byte_t [CDD_PACKET_BYTES-1:0] cdd_packet_t;

endpackage
